/* spmm_top.f */
+incdir+include
source/spmm_cfg_pkg.sv
source/spmm_ctrl_pkg.sv
source/prefix_scan.sv
source/spmm_pe.sv
source/rhs_buffer.sv
source/out_buffer.sv
source/spmm_control.sv
source/spmm_top.sv
verification/spmm_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the spmm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module spmm_tb -f spmm_top.f -o spmm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/spmm_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Test OK$'; then
    exit 0
fi
exit 1

/* include/spmm_tb_check.svh */
`ifndef SPMM_TB_CHECK_SVH
`define SPMM_TB_CHECK_SVH

localparam int CHK_N = spmm_cfg_pkg::DEFAULT_N;
localparam int CHK_W = spmm_cfg_pkg::DEFAULT_W;

typedef logic [CHK_W-1:0] chk_elem_t;
typedef chk_elem_t [CHK_N-1:0] chk_vec_t;
// matrices are [row][column]
typedef chk_vec_t [CHK_N-1:0] chk_matrix_t;
typedef logic [$clog2(CHK_N):0] chk_ptr_t;
typedef logic [$clog2(CHK_N)-1:0] chk_col_t;

// expected product, row r takes nonzeros ptr[r-1] up to ptr[r]-1
function automatic chk_matrix_t spmm_reference(input chk_matrix_t rhs,
                                               input chk_ptr_t [CHK_N-1:0] ptr,
                                               input chk_col_t [CHK_N-1:0] col,
                                               input chk_vec_t data);
    chk_matrix_t prod;
    int lo;
    int hi;
    prod = '0;
    lo = 0;
    for (int r = 0; r < CHK_N; r++) begin
        hi = int'(ptr[r]);
        for (int i = lo; i < hi; i++) begin
            for (int c = 0; c < CHK_N; c++) begin
                // wraps at CHK_W bits like the hardware
                prod[r][c] = prod[r][c] + data[i] * rhs[col[i]][c];
            end
        end
        lo = hi;
    end
    return prod;
endfunction

// stops the run at the first mismatch
task automatic check_value(input string name, input chk_elem_t got,
                           input chk_elem_t expected);
    if (got !== expected) begin
        $display("ERROR at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
        $display("Test FAILED");
        $fatal(1, "result mismatch on %s", name);
    end
endtask

`endif

/* verification/spmm_tb.sv */
module spmm_tb;

    localparam int n = spmm_cfg_pkg::DEFAULT_N;
    localparam int w = spmm_cfg_pkg::DEFAULT_W;
    localparam int rows = spmm_cfg_pkg::ROWS_PER_BEAT;
    localparam int beats = spmm_cfg_pkg::beat_count(n);
    localparam int lat = spmm_ctrl_pkg::MUL_STAGES + $clog2(n) + spmm_ctrl_pkg::DIFF_STAGES;
    localparam int jobs = 15;
    localparam int reset_cycles = 16;
    localparam int job_cycles = 2 * beats + lat + 20;

`include "spmm_tb_check.svh"

    logic clock;
    logic reset;
    logic rhs_ready;
    logic lhs_ready;
    logic out_ready;
    logic rhs_start;
    logic lhs_start;
    logic out_start;
    logic [rows-1:0][n-1:0][w-1:0] rhs_data;
    chk_ptr_t [n-1:0] lhs_ptr;
    chk_col_t [n-1:0] lhs_col;
    chk_vec_t lhs_data;
    logic [rows-1:0][n-1:0][w-1:0] out_data;

    // operands of the job being prepared
    chk_matrix_t job_rhs;
    chk_ptr_t [n-1:0] job_ptr;
    chk_col_t [n-1:0] job_col;
    chk_vec_t job_data;

    chk_matrix_t exp_q[$];
    chk_matrix_t got_q[$];
    int compared = 0;
    int seed = 35;

    spmm_top #(.n(n), .w(w)) DUT (
        .clock     (clock),
        .reset     (reset),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .out_ready (out_ready),
        .rhs_start (rhs_start),
        .lhs_start (lhs_start),
        .out_start (out_start),
        .rhs_data  (rhs_data),
        .lhs_ptr   (lhs_ptr),
        .lhs_col   (lhs_col),
        .lhs_data  (lhs_data),
        .out_data  (out_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // 0 selects rhs_ready, 1 lhs_ready, anything else out_ready
    function automatic logic ready_level(input int sel);
        case (sel)
            0: return rhs_ready;
            1: return lhs_ready;
            default: return out_ready;
        endcase
    endfunction

    // returns at the drive point of the first cycle with the level high
    task automatic wait_ready(input int sel, output int cycles);
        cycles = 0;
        while (!ready_level(sel)) begin
            @(posedge clock);
            #1;
            cycles++;
        end
    endtask

    task automatic check_bus_zero();
        for (int k = 0; k < rows; k++) begin
            for (int c = 0; c < n; c++) begin
                check_value($sformatf("out_data[%0d][%0d]", k, c), out_data[k][c], '0);
            end
        end
    endtask

    // one nonzero per row
    task automatic make_simple();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                job_rhs[r][c] = chk_elem_t'(r + 2 * c);
            end
            job_ptr[r] = chk_ptr_t'(r + 1);
            job_col[r] = chk_col_t'((3 * r + 1) % n);
            job_data[r] = chk_elem_t'(r + 1);
        end
    endtask

    // six nonzeros all in row 5, the remaining lanes carry junk
    task automatic make_sparse();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                job_rhs[r][c] = chk_elem_t'(r * n + c);
            end
            job_ptr[r] = (r < 5) ? chk_ptr_t'(0) : chk_ptr_t'(6);
            job_col[r] = chk_col_t'((5 * r) % n);
            job_data[r] = (r < 6) ? chk_elem_t'(r + 2) : chk_elem_t'(255);
        end
    endtask

    // large values, even rows hold two nonzeros and odd rows none
    task automatic make_wrap();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                job_rhs[r][c] = chk_elem_t'(240 + ((r ^ c) % 16));
            end
            job_ptr[r] = chk_ptr_t'((r / 2 + 1) * 2);
            job_col[r] = chk_col_t'(n - 1 - r);
            job_data[r] = chk_elem_t'(255 - r);
        end
    endtask

    task automatic make_random();
        int p;
        p = 0;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                job_rhs[r][c] = chk_elem_t'($random(seed));
            end
            p = p + int'({$random(seed)} % 3);
            if (p > n) begin
                p = n;
            end
            job_ptr[r] = chk_ptr_t'(p);
            job_col[r] = chk_col_t'({$random(seed)} % n);
            job_data[r] = chk_elem_t'($random(seed));
        end
    endtask

    task automatic run_job();
        int cycles;
        exp_q.push_back(spmm_reference(job_rhs, job_ptr, job_col, job_data));
        wait_ready(0, cycles);
        for (int b = 0; b < beats; b++) begin
            if (b > 0) begin
                @(posedge clock);
                #1;
            end
            check_value("lhs_ready", chk_elem_t'(lhs_ready), '0);
            rhs_start = (b == 0);
            for (int k = 0; k < rows; k++) begin
                rhs_data[k] = job_rhs[b * rows + k];
            end
        end
        @(posedge clock);
        #1;
        rhs_data = '0;
        // WAIT_LHS is entered right at the edge after the last beat
        wait_ready(1, cycles);
        check_value("lhs_ready wait cycles", chk_elem_t'(cycles), '0);
        check_value("out_ready", chk_elem_t'(out_ready), '0);
        lhs_start = 1'b1;
        lhs_ptr = job_ptr;
        lhs_col = job_col;
        lhs_data = job_data;
        @(posedge clock);
        #1;
        lhs_start = 1'b0;
        lhs_ptr = '0;
        lhs_col = '0;
        lhs_data = '0;
        wait_ready(2, cycles);
        check_value("out_ready delay", chk_elem_t'(cycles + 1), chk_elem_t'(lat + 1));
        out_start = 1'b1;
        @(posedge clock);
        #1;
        out_start = 1'b0;
    endtask

    // beat 0 shows with out_start, the bus is zero outside the window
    initial begin
        chk_matrix_t got;
        forever begin
            @(negedge clock);
            if (out_start) begin
                for (int b = 0; b < beats; b++) begin
                    if (b > 0) begin
                        @(negedge clock);
                    end
                    for (int k = 0; k < rows; k++) begin
                        got[b * rows + k] = out_data[k];
                    end
                end
                got_q.push_back(got);
            end else begin
                check_bus_zero();
            end
        end
    end

    initial begin
        chk_matrix_t got;
        chk_matrix_t expected;
        forever begin
            @(posedge clock);
            if (got_q.size() > 0) begin
                got = got_q.pop_front();
                expected = exp_q.pop_front();
                for (int r = 0; r < n; r++) begin
                    for (int c = 0; c < n; c++) begin
                        check_value($sformatf("out_data row %0d column %0d", r, c),
                                    got[r][c], expected[r][c]);
                    end
                end
                compared++;
            end
        end
    end

    initial begin
        #((reset_cycles + 4 + jobs * job_cycles) * 8);
        $display("timeout: the jobs did not finish in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b0;
        rhs_start = 1'b0;
        lhs_start = 1'b0;
        out_start = 1'b0;
        rhs_data = '0;
        lhs_ptr = '0;
        lhs_col = '0;
        lhs_data = '0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clock);
            #1;
            check_value("rhs_ready", chk_elem_t'(rhs_ready), '0);
            check_value("lhs_ready", chk_elem_t'(lhs_ready), '0);
            check_value("out_ready", chk_elem_t'(out_ready), '0);
        end
        reset = 1'b1;
        @(posedge clock);
        #1;
        check_value("rhs_ready", chk_elem_t'(rhs_ready), chk_elem_t'(1));
        make_simple();
        run_job();
        make_sparse();
        run_job();
        make_wrap();
        run_job();
        for (int j = 0; j < jobs - 3; j++) begin
            make_random();
            run_job();
        end
        while (compared < jobs) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        $display("Test OK");
        $finish;
    end

endmodule

/* source/spmm_top.sv */
module spmm_top #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N,
    parameter int w = spmm_cfg_pkg::DEFAULT_W
) (
    input  logic clock,
    input  logic reset,
    output logic rhs_ready,
    output logic lhs_ready,
    output logic out_ready,
    input  logic rhs_start,
    input  logic lhs_start,
    input  logic out_start,
    input  logic [spmm_cfg_pkg::ROWS_PER_BEAT-1:0][n-1:0][w-1:0] rhs_data,
    input  logic [n-1:0][$clog2(n):0] lhs_ptr,
    input  logic [n-1:0][$clog2(n)-1:0] lhs_col,
    input  logic [n-1:0][w-1:0] lhs_data,
    output logic [spmm_cfg_pkg::ROWS_PER_BEAT-1:0][n-1:0][w-1:0] out_data
);
    localparam int bw = spmm_cfg_pkg::beat_bits(n);

    logic rhs_write;
    logic capture;
    logic send;
    logic [bw-1:0] rhs_beat;
    logic [bw-1:0] out_beat;

    // both indexed [column][row]
    logic [n-1:0][n-1:0][w-1:0] rhs_cols;
    logic [n-1:0][n-1:0][w-1:0] pe_sums;

    spmm_control #(.n(n)) u_control (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .lhs_start (lhs_start),
        .out_start (out_start),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .out_ready (out_ready),
        .rhs_write (rhs_write),
        .rhs_beat  (rhs_beat),
        .capture   (capture),
        .send      (send),
        .out_beat  (out_beat)
    );

    rhs_buffer #(.n(n), .w(w)) u_rhs_buffer (
        .clock     (clock),
        .rhs_write (rhs_write),
        .rhs_beat  (rhs_beat),
        .rhs_data  (rhs_data),
        .rhs_cols  (rhs_cols)
    );

    // one PE per result column, all see the same sparse operand
    for (genvar c = 0; c < n; c++) begin : g_pe
        spmm_pe #(.n(n), .w(w)) u_pe (
            .clock    (clock),
            .reset    (reset),
            .lhs_ptr  (lhs_ptr),
            .lhs_col  (lhs_col),
            .lhs_data (lhs_data),
            .rhs_col  (rhs_cols[c]),
            .row_sums (pe_sums[c])
        );
    end

    out_buffer #(.n(n), .w(w)) u_out_buffer (
        .clock    (clock),
        .capture  (capture),
        .send     (send),
        .out_beat (out_beat),
        .pe_sums  (pe_sums),
        .out_data (out_data)
    );

endmodule

/* source/spmm_control.sv */
module spmm_control #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N
) (
    input  logic clock,
    input  logic reset,
    input  logic rhs_start,
    input  logic lhs_start,
    input  logic out_start,
    output logic rhs_ready,
    output logic lhs_ready,
    output logic out_ready,
    output logic rhs_write,
    output logic [spmm_cfg_pkg::beat_bits(n)-1:0] rhs_beat,
    output logic capture,
    output logic send,
    output logic [spmm_cfg_pkg::beat_bits(n)-1:0] out_beat
);
    localparam int beats = spmm_cfg_pkg::beat_count(n);
    localparam int bw = spmm_cfg_pkg::beat_bits(n);
    // cycles from lhs_start until the PE results are valid
    localparam int lat = spmm_ctrl_pkg::MUL_STAGES + $clog2(n) + spmm_ctrl_pkg::DIFF_STAGES;
    localparam int lw = $clog2(lat + 1);
    localparam logic [bw-1:0] last_beat = bw'(beats - 1);
    localparam logic [lw-1:0] last_lat = lw'(lat);

    spmm_ctrl_pkg::ctrl_state_t state;
    spmm_ctrl_pkg::ctrl_state_t next_state;
    logic [bw-1:0] beat_cnt;
    logic [lw-1:0] lat_cnt;
    logic rhs_go;
    logic lhs_go;
    logic out_go;

    assign rhs_go = (state == spmm_ctrl_pkg::IDLE) && rhs_start;
    assign lhs_go = (state == spmm_ctrl_pkg::WAIT_LHS) && lhs_start;
    assign out_go = (state == spmm_ctrl_pkg::HOLD_OUT) && out_start;

    // the start cycle already carries beat 0
    assign rhs_write = rhs_go || (state == spmm_ctrl_pkg::LOAD_RHS);
    assign send = out_go || (state == spmm_ctrl_pkg::SEND_OUT);
    assign capture = (state == spmm_ctrl_pkg::COMPUTE) && (lat_cnt == last_lat);

    // counter rests at zero between transfers
    assign rhs_beat = beat_cnt;
    assign out_beat = beat_cnt;

    always_comb begin
        next_state = state;
        case (state)
            spmm_ctrl_pkg::IDLE:     if (rhs_go) next_state = spmm_ctrl_pkg::LOAD_RHS;
            spmm_ctrl_pkg::LOAD_RHS: if (beat_cnt == last_beat) next_state = spmm_ctrl_pkg::WAIT_LHS;
            spmm_ctrl_pkg::WAIT_LHS: if (lhs_go) next_state = spmm_ctrl_pkg::COMPUTE;
            spmm_ctrl_pkg::COMPUTE:  if (capture) next_state = spmm_ctrl_pkg::HOLD_OUT;
            spmm_ctrl_pkg::HOLD_OUT: if (out_go) next_state = spmm_ctrl_pkg::SEND_OUT;
            spmm_ctrl_pkg::SEND_OUT: if (beat_cnt == last_beat) next_state = spmm_ctrl_pkg::IDLE;
            default:                 next_state = spmm_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= spmm_ctrl_pkg::IDLE;
            beat_cnt <= '0;
            lat_cnt <= '0;
        end else begin
            state <= next_state;
            // shared by load and send, they never overlap
            if (rhs_write || send) begin
                beat_cnt <= (beat_cnt == last_beat) ? '0 : beat_cnt + 1'b1;
            end
            if (lhs_go || ((state == spmm_ctrl_pkg::COMPUTE) && !capture)) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
        end
    end

    // ready levels follow the state one edge later, low in reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rhs_ready <= 1'b0;
            lhs_ready <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            rhs_ready <= next_state == spmm_ctrl_pkg::IDLE;
            lhs_ready <= next_state == spmm_ctrl_pkg::WAIT_LHS;
            out_ready <= next_state == spmm_ctrl_pkg::HOLD_OUT;
        end
    end

    // starts only while the matching ready is up
    a_rhs_start_legal: assert property (@(posedge clock) disable iff (!reset)
        rhs_start |-> rhs_ready);
    a_lhs_start_legal: assert property (@(posedge clock) disable iff (!reset)
        lhs_start |-> lhs_ready);
    a_out_start_legal: assert property (@(posedge clock) disable iff (!reset)
        out_start |-> out_ready);

    // exactly one capture per job, L cycles after the operand
    a_capture_follows: assert property (@(posedge clock) disable iff (!reset)
        lhs_start |-> ##lat capture);
    a_capture_only: assert property (@(posedge clock) disable iff (!reset)
        capture |-> $past(lhs_start, lat));

    // every transfer leaves the beat counter back at beat 0
    a_beat_rest: assert property (@(posedge clock) disable iff (!reset)
        !(rhs_write || send) |-> beat_cnt == '0);

endmodule

/* source/out_buffer.sv */
module out_buffer #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N,
    parameter int w = spmm_cfg_pkg::DEFAULT_W
) (
    input  logic clock,
    input  logic capture,
    input  logic send,
    input  logic [spmm_cfg_pkg::beat_bits(n)-1:0] out_beat,
    input  logic [n-1:0][n-1:0][w-1:0] pe_sums,
    output logic [spmm_cfg_pkg::ROWS_PER_BEAT-1:0][n-1:0][w-1:0] out_data
);
    localparam int cw = $clog2(n);
    localparam int rows = spmm_cfg_pkg::ROWS_PER_BEAT;

    // result held as [row][column]
    logic [n-1:0][n-1:0][w-1:0] result;
    logic [cw-1:0] row_base;

    // PE c delivers column c, so transpose on the way in
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int r = 0; r < n; r++) begin
                for (int c = 0; c < n; c++) begin
                    result[r][c] <= pe_sums[c][r];
                end
            end
        end
    end

    assign row_base = cw'(out_beat) * cw'(rows);

    // bus stays at zero outside the send window
    always_comb begin
        out_data = '0;
        if (send) begin
            for (int k = 0; k < rows; k++) begin
                out_data[k] = result[row_base + cw'(k)];
            end
        end
    end

endmodule

/* source/rhs_buffer.sv */
module rhs_buffer #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N,
    parameter int w = spmm_cfg_pkg::DEFAULT_W
) (
    input  logic clock,
    input  logic rhs_write,
    input  logic [spmm_cfg_pkg::beat_bits(n)-1:0] rhs_beat,
    input  logic [spmm_cfg_pkg::ROWS_PER_BEAT-1:0][n-1:0][w-1:0] rhs_data,
    output logic [n-1:0][n-1:0][w-1:0] rhs_cols
);
    localparam int cw = $clog2(n);
    localparam int rows = spmm_cfg_pkg::ROWS_PER_BEAT;

    // first dense row written by this beat
    logic [cw-1:0] row_base;

    assign row_base = cw'(rhs_beat) * cw'(rows);

    // kept transposed, [column][row], so a PE reads its column whole
    always_ff @(posedge clock) begin
        if (rhs_write) begin
            for (int k = 0; k < rows; k++) begin
                for (int c = 0; c < n; c++) begin
                    rhs_cols[c][row_base + cw'(k)] <= rhs_data[k][c];
                end
            end
        end
    end

    // the controller must keep the beat inside the matrix
    a_beat_in_range: assert property (@(posedge clock)
        rhs_write |-> int'(rhs_beat) < spmm_cfg_pkg::beat_count(n));

endmodule

/* source/spmm_pe.sv */
module spmm_pe #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N,
    parameter int w = spmm_cfg_pkg::DEFAULT_W
) (
    input  logic clock,
    input  logic reset,
    input  logic [n-1:0][$clog2(n):0] lhs_ptr,
    input  logic [n-1:0][$clog2(n)-1:0] lhs_col,
    input  logic [n-1:0][w-1:0] lhs_data,
    input  logic [n-1:0][w-1:0] rhs_col,
    output logic [n-1:0][w-1:0] row_sums
);
    localparam int cw = $clog2(n);
    localparam int mul_stages = spmm_ctrl_pkg::MUL_STAGES;
    localparam int diff_stages = spmm_ctrl_pkg::DIFF_STAGES;
    // pointers wait out the multiply and the scan
    localparam int ptr_stages = mul_stages + $clog2(n);

    logic [n-1:0][w-1:0] prod_q [mul_stages];
    logic [n-1:0][cw:0] ptr_q [ptr_stages];
    logic [n-1:0][cw:0] ptr_lo;
    logic [n-1:0][w-1:0] prefix;
    logic [n-1:0][w-1:0] diff_q [diff_stages];

    // inclusive prefix up to lane ptr-1, a zero pointer means nothing
    function automatic logic [w-1:0] pick(input logic [n-1:0][w-1:0] sums,
                                          input logic [cw:0] ptr);
        return (ptr == '0) ? '0 : sums[ptr - 1'b1];
    endfunction

    // each nonzero selects the dense element of its column index
    always_ff @(posedge clock) begin
        for (int i = 0; i < n; i++) begin
            prod_q[0][i] <= lhs_data[i] * rhs_col[lhs_col[i]];
        end
        for (int s = 1; s < mul_stages; s++) begin
            prod_q[s] <= prod_q[s - 1];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < ptr_stages; s++) begin
                ptr_q[s] <= '0;
            end
        end else begin
            ptr_q[0] <= lhs_ptr;
            for (int s = 1; s < ptr_stages; s++) begin
                ptr_q[s] <= ptr_q[s - 1];
            end
        end
    end

    prefix_scan #(.n(n), .w(w)) u_scan (
        .clock     (clock),
        .reset     (reset),
        .lanes_in  (prod_q[mul_stages - 1]),
        .lanes_out (prefix)
    );

    // row 0 starts at lane 0
    always_comb begin
        ptr_lo[0] = '0;
        for (int r = 1; r < n; r++) begin
            ptr_lo[r] = ptr_q[ptr_stages - 1][r - 1];
        end
    end

    always_ff @(posedge clock) begin
        for (int r = 0; r < n; r++) begin
            diff_q[0][r] <= pick(prefix, ptr_q[ptr_stages - 1][r]) - pick(prefix, ptr_lo[r]);
        end
        for (int s = 1; s < diff_stages; s++) begin
            diff_q[s] <= diff_q[s - 1];
        end
    end

    assign row_sums = diff_q[diff_stages - 1];

    // CSR pointers nondecreasing and within n as they enter
    for (genvar r = 1; r < n; r++) begin : g_ptr_order
        a_ptr_order: assert property (@(posedge clock) disable iff (!reset)
            ptr_q[0][r] >= ptr_q[0][r - 1]);
    end
    a_ptr_range: assert property (@(posedge clock) disable iff (!reset)
        ptr_q[0][n - 1] <= (cw + 1)'(n));

endmodule

/* source/prefix_scan.sv */
module prefix_scan #(
    parameter int n = spmm_cfg_pkg::DEFAULT_N,
    parameter int w = spmm_cfg_pkg::DEFAULT_W
) (
    input  logic clock,
    input  logic reset,
    input  logic [n-1:0][w-1:0] lanes_in,
    output logic [n-1:0][w-1:0] lanes_out
);
    localparam int stages = $clog2(n);

    // registered partial sums, one row per stage
    logic [n-1:0][w-1:0] sums [stages];
    // level 0 is the input, level s+1 is stage s
    logic [n-1:0][w-1:0] level [stages + 1];

    always_comb begin
        level[0] = lanes_in;
        for (int s = 0; s < stages; s++) begin
            level[s + 1] = sums[s];
        end
    end

    // Hillis-Steele: stage s adds the lane 2^s below, if there is one
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < stages; s++) begin
                sums[s] <= '0;
            end
        end else begin
            for (int s = 0; s < stages; s++) begin
                for (int j = 0; j < n; j++) begin
                    if (j >= (1 << s)) begin
                        sums[s][j] <= level[s][j] + level[s][j - (1 << s)];
                    end else begin
                        sums[s][j] <= level[s][j];
                    end
                end
            end
        end
    end

    assign lanes_out = level[stages];

endmodule

/* source/spmm_ctrl_pkg.sv */
package spmm_ctrl_pkg;

    // sequencer states, one job at a time
    typedef enum logic [2:0] {
        IDLE,
        LOAD_RHS,
        WAIT_LHS,
        COMPUTE,
        HOLD_OUT,
        SEND_OUT
    } ctrl_state_t;

    // register stages of the lane multiply
    localparam int MUL_STAGES = 1;

    // register stages after the row difference
    localparam int DIFF_STAGES = 1;

    // the scan in between adds log2(n) stages, so the
    // full latency is MUL_STAGES + log2(n) + DIFF_STAGES

endpackage

/* source/spmm_cfg_pkg.sv */
package spmm_cfg_pkg;

    // default problem size, overridden through the top level parameters
    localparam int DEFAULT_N = 16;

    // element width, products and sums wrap at this width
    localparam int DEFAULT_W = 8;

    // rows moved per beat on both the dense load and the result send
    localparam int ROWS_PER_BEAT = 4;

    // number of beats to move a full n-row matrix
    function automatic int beat_count(input int n);
        return n / ROWS_PER_BEAT;
    endfunction

    // width of a beat index, never below one bit
    function automatic int beat_bits(input int n);
        int beats;
        beats = beat_count(n);
        if (beats > 1) begin
            return $clog2(beats);
        end
        return 1;
    endfunction

endpackage
